// File: logic/fcnvt_pkg.sv
package fcnvt_pkg;

  // Binary64 operand layout
  localparam int DBL_W      = 64;
  localparam int DBL_EXP_W  = 11;
  localparam int DBL_FRAC_W = 52;
  localparam int DBL_BIAS   = 1023;

  // Binary16 result layout
  localparam int HALF_W      = 16;
  localparam int HALF_EXP_W  = 5;
  localparam int HALF_FRAC_W = 10;
  localparam int HALF_BIAS   = 15;

  // Every NaN collapses to this one
  localparam logic [HALF_W-1:0] HALF_QNAN = 16'h7e00;

  // RISC-V rounding modes, unlisted codes round like RNE
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } rm_t;

  // Exception flags in fflags order, no divide-by-zero here
  typedef struct packed {
    logic nv;
    logic of;
    logic uf;
    logic nx;
  } fflags_t;

  // Dispatch to lane
  typedef struct packed {
    logic [DBL_W-1:0] src;
    rm_t              rm;
  } dtoh_in_t;

  // Lane to collect
  typedef struct packed {
    logic [HALF_W-1:0] res;
    fflags_t           flags;
  } dtoh_out_t;

endpackage

// File: logic/fcnvt_lane_if.sv
`timescale 1ns/1ps

// One lane hop: a valid strobe plus whatever payload the hop carries
interface fcnvt_lane_if #(
  parameter type payload_t = logic
) ();

  // Payload is only meaningful while valid is high
  logic     valid;
  payload_t payload;

  // Producer side
  modport src (
    output valid,
    output payload
  );

  // Consumer side, no ready back to the producer
  modport snk (
    input valid,
    input payload
  );

endinterface

// File: logic/fcnvt_dtoh_sh.sv
`timescale 1ns/1ps

module fcnvt_dtoh_sh
  import fcnvt_pkg::*;
(
  input  logic [DBL_EXP_W-1:0]   sh_cnt,
  input  logic [DBL_FRAC_W-1:0]  sh_src,
  output logic [HALF_FRAC_W:0]   sh_f_v,
  output logic [DBL_FRAC_W+1:0]  sh_f_x
);

  // Shifter window covers -15 down to -26
  localparam int SH_TOP = -15;
  localparam int SH_BOT = -26;

  logic signed [DBL_EXP_W-1:0] cnt_s;
  logic                        in_range;
  logic [3:0]                  sh_amt;
  logic [HALF_FRAC_W+DBL_FRAC_W+2:0] aligned;

  // Exponent arrives as two's complement
  assign cnt_s = sh_cnt;

  assign in_range = (cnt_s <= DBL_EXP_W'(SH_TOP)) && (cnt_s >= DBL_EXP_W'(SH_BOT));

  // Zero shift at -15, eleven at -26
  assign sh_amt = 4'(DBL_EXP_W'(SH_TOP) - cnt_s);

  // At -15 the hidden one lands on bit 9 of the kept field,
  // the first dropped bit is the guard, the rest feed sticky
  assign aligned = {2'b01, sh_src, {(HALF_FRAC_W+1){1'b0}}} >> sh_amt;

  always_comb begin
    if (in_range) begin
      // Kept bits on top, dropped bits below
      sh_f_v = aligned[HALF_FRAC_W+DBL_FRAC_W+2 -: HALF_FRAC_W+1];
      sh_f_x = aligned[DBL_FRAC_W+1:0];
    end else begin
      // Far below the smallest subnormal
      // Nothing kept, guard clear, sticky set
      sh_f_v = '0;
      sh_f_x = {3'b001, {(DBL_FRAC_W-1){1'b0}}};
    end
  end

endmodule

// File: logic/fcnvt_dtoh_lane.sv
`timescale 1ns/1ps

module fcnvt_dtoh_lane
  import fcnvt_pkg::*;
(
  input  logic      forever_cpuclk,
  input  logic      reset,
  fcnvt_lane_if.snk lane_in,
  fcnvt_lane_if.src lane_out
);

  dtoh_in_t op;
  logic sign;
  logic [DBL_EXP_W-1:0]  exp_d;
  logic [DBL_FRAC_W-1:0] frac_d;
  logic exp_zero;
  logic exp_ones;
  logic frac_zero;
  logic is_zero;
  logic is_inf;
  logic is_nan;
  logic is_snan;
  logic signed [DBL_EXP_W:0] exp_unb;
  logic signed [DBL_EXP_W:0] exp_half;
  logic ovf_pre;
  logic tiny;
  logic [HALF_FRAC_W:0]  sh_f_v;
  logic [DBL_FRAC_W+1:0] sh_f_x;
  logic [HALF_EXP_W-1:0]  h_exp;
  logic [HALF_FRAC_W-1:0] h_frac;
  logic guard;
  logic sticky;
  logic inexact;
  logic rnd_up;
  logic [HALF_W-2:0] rounded;
  logic ovf;
  logic ovf_to_inf;
  dtoh_out_t res_c;
  dtoh_out_t res_q;
  logic valid_q;

  assign op     = lane_in.payload;
  assign sign   = op.src[DBL_W-1];
  assign exp_d  = op.src[DBL_W-2 -: DBL_EXP_W];
  assign frac_d = op.src[DBL_FRAC_W-1:0];

  // Operand class
  assign exp_zero  = (exp_d == '0);
  assign exp_ones  = (exp_d == '1);
  assign frac_zero = (frac_d == '0);
  assign is_zero   = exp_zero & frac_zero;
  assign is_inf    = exp_ones & frac_zero;
  assign is_nan    = exp_ones & ~frac_zero;
  assign is_snan   = is_nan & ~frac_d[DBL_FRAC_W-1];

  // Unbiased exponent, binary64 subnormals sit at -1023
  assign exp_unb  = $signed({1'b0, exp_d}) - (DBL_EXP_W+1)'(DBL_BIAS);
  assign exp_half = exp_unb + (DBL_EXP_W+1)'(HALF_BIAS);

  // Above 2^15 never fits, below 2^-14 is tiny
  assign ovf_pre = exp_unb > (DBL_EXP_W+1)'(HALF_BIAS);
  assign tiny    = exp_unb < (DBL_EXP_W+1)'(1 - HALF_BIAS);

  fcnvt_dtoh_sh dtoh_sh_i (
    .sh_cnt (exp_unb[DBL_EXP_W-1:0]),
    .sh_src (frac_d),
    .sh_f_v (sh_f_v),
    .sh_f_x (sh_f_x)
  );

  // Pick the truncated half value and the round bits
  always_comb begin
    if (tiny) begin
      {h_exp, h_frac} = {{(HALF_EXP_W-1){1'b0}}, sh_f_v};
      guard  = sh_f_x[DBL_FRAC_W+1];
      sticky = |sh_f_x[DBL_FRAC_W:0];
    end else begin
      h_exp  = exp_half[HALF_EXP_W-1:0];
      h_frac = frac_d[DBL_FRAC_W-1 -: HALF_FRAC_W];
      guard  = frac_d[DBL_FRAC_W-HALF_FRAC_W-1];
      sticky = |frac_d[DBL_FRAC_W-HALF_FRAC_W-2:0];
    end
  end

  assign inexact = guard | sticky;

  // Increment decision per mode
  always_comb begin
    case (op.rm)
      RTZ:     rnd_up = 1'b0;
      RDN:     rnd_up = sign & inexact;
      RUP:     rnd_up = ~sign & inexact;
      RMM:     rnd_up = guard;
      default: rnd_up = guard & (sticky | h_frac[0]);
    endcase
  end

  // Fraction carry ripples into the exponent on its own
  assign rounded = {h_exp, h_frac} + (HALF_W-1)'(rnd_up);
  assign ovf = ovf_pre | (rounded[HALF_W-2 -: HALF_EXP_W] == '1);

  // Overflow saturates toward zero in the directed modes
  always_comb begin
    case (op.rm)
      RTZ:     ovf_to_inf = 1'b0;
      RDN:     ovf_to_inf = sign;
      RUP:     ovf_to_inf = ~sign;
      default: ovf_to_inf = 1'b1;
    endcase
  end

  // Result and flags
  always_comb begin
    res_c = '0;
    if (is_nan) begin
      res_c.res      = HALF_QNAN;
      res_c.flags.nv = is_snan;
    end else if (is_inf) begin
      res_c.res = {sign, {HALF_EXP_W{1'b1}}, {HALF_FRAC_W{1'b0}}};
    end else if (is_zero) begin
      res_c.res = {sign, {(HALF_W-1){1'b0}}};
    end else if (ovf) begin
      if (ovf_to_inf) begin
        res_c.res = {sign, {HALF_EXP_W{1'b1}}, {HALF_FRAC_W{1'b0}}};
      end else begin
        res_c.res = {sign, {(HALF_EXP_W-1){1'b1}}, 1'b0, {HALF_FRAC_W{1'b1}}};
      end
      res_c.flags.of = 1'b1;
      res_c.flags.nx = 1'b1;
    end else begin
      res_c.res      = {sign, rounded};
      res_c.flags.nx = inexact;
      // Tininess judged before rounding
      res_c.flags.uf = tiny & inexact;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= lane_in.valid;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (lane_in.valid) begin
      res_q <= res_c;
    end
  end

  assign lane_out.valid   = valid_q;
  assign lane_out.payload = res_q;

  // Overflow always reports inexact too
  a_of_implies_nx: assert property (@(posedge forever_cpuclk) disable iff (reset)
    valid_q |-> (!res_q.flags.of || res_q.flags.nx));

endmodule

// File: logic/fcnvt_dispatch.sv
`timescale 1ns/1ps

module fcnvt_dispatch
  import fcnvt_pkg::*;
#(
  parameter int LANES = 4
) (
  input  logic                   forever_cpuclk,
  input  logic                   reset,
  input  logic                   in_valid,
  input  logic [LANES*DBL_W-1:0] in_src,
  input  rm_t                    in_rm,
  fcnvt_lane_if.src              lane_o [LANES]
);

  logic     valid_q;
  dtoh_in_t pl_q [LANES];

  // One strobe serves every lane
  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  for (genvar g = 0; g < LANES; g++) begin : g_lane
    dtoh_in_t pl_c;

    // Lane 0 takes the low operand
    assign pl_c.src = in_src[g*DBL_W +: DBL_W];
    assign pl_c.rm  = in_rm;

    always_ff @(posedge forever_cpuclk) begin
      if (in_valid) begin
        pl_q[g] <= pl_c;
      end
    end

    assign lane_o[g].valid   = valid_q;
    assign lane_o[g].payload = pl_q[g];
  end

  // Only the five defined modes may enter the pipe
  a_rm_legal: assert property (@(posedge forever_cpuclk) disable iff (reset)
    in_valid |-> (in_rm inside {RNE, RTZ, RDN, RUP, RMM}));

endmodule

// File: logic/fcnvt_collect.sv
`timescale 1ns/1ps

module fcnvt_collect
  import fcnvt_pkg::*;
#(
  parameter int LANES = 4
) (
  input  logic                    forever_cpuclk,
  input  logic                    reset,
  fcnvt_lane_if.snk               lane_i [LANES],
  output logic                    out_valid,
  output logic [LANES*HALF_W-1:0] out_res,
  output fflags_t                 out_flags
);

  logic [LANES-1:0]        lane_valid;
  logic [LANES*HALF_W-1:0] res_cat;
  fflags_t [LANES-1:0]     lane_flags;
  fflags_t                 flags_or;

  for (genvar g = 0; g < LANES; g++) begin : g_lane
    dtoh_out_t pl;

    assign pl            = lane_i[g].payload;
    assign lane_valid[g] = lane_i[g].valid;
    // Results stay in lane order
    assign res_cat[g*HALF_W +: HALF_W] = pl.res;
    assign lane_flags[g] = pl.flags;
  end

  // Sticky-style merge across lanes
  always_comb begin
    flags_or = '0;
    for (int i = 0; i < LANES; i++) begin
      flags_or = flags_or | lane_flags[i];
    end
  end

  // Lanes move in lockstep, lane 0 speaks for all
  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_res   <= '0;
      out_flags <= '0;
    end else begin
      out_valid <= lane_valid[0];
      if (lane_valid[0]) begin
        out_res   <= res_cat;
        out_flags <= flags_or;
      end
    end
  end

  // No lane may run ahead or fall behind
  a_lanes_agree: assert property (@(posedge forever_cpuclk) disable iff (reset)
    (lane_valid == '0) || (&lane_valid));

endmodule

// File: logic/fcnvt_dtoh_top.sv
`timescale 1ns/1ps

module fcnvt_dtoh_top
  import fcnvt_pkg::*;
#(
  parameter int LANES = 4
) (
  input  logic                    forever_cpuclk,
  input  logic                    reset,
  input  logic                    in_valid,
  input  logic [LANES*DBL_W-1:0]  in_src,
  input  rm_t                     in_rm,
  output logic                    out_valid,
  output logic [LANES*HALF_W-1:0] out_res,
  output fflags_t                 out_flags
);

  // Dispatch to lanes, then lanes to collect
  fcnvt_lane_if #(.payload_t(dtoh_in_t))  in_lane  [LANES] ();
  fcnvt_lane_if #(.payload_t(dtoh_out_t)) out_lane [LANES] ();

  // Stage 1
  fcnvt_dispatch #(
    .LANES (LANES)
  ) dispatch_i (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_src         (in_src),
    .in_rm          (in_rm),
    .lane_o         (in_lane)
  );

  // Stage 2, one converter per lane
  for (genvar g = 0; g < LANES; g++) begin : g_lane
    fcnvt_dtoh_lane dtoh_lane_i (
      .forever_cpuclk (forever_cpuclk),
      .reset          (reset),
      .lane_in        (in_lane[g]),
      .lane_out       (out_lane[g])
    );
  end

  // Stage 3
  fcnvt_collect #(
    .LANES (LANES)
  ) collect_i (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .lane_i         (out_lane),
    .out_valid      (out_valid),
    .out_res        (out_res),
    .out_flags      (out_flags)
  );

endmodule

// File: testbench/fcnvt_checker.sv
`timescale 1ns/1ps

module fcnvt_checker
  import fcnvt_pkg::*;
#(
  parameter int LANES = 4
) (
  input  logic                    forever_cpuclk,
  input  logic                    reset,
  input  logic                    in_valid,
  input  logic [LANES*DBL_W-1:0]  in_src,
  input  logic [2:0]              in_rm,
  input  logic                    out_valid,
  input  logic [LANES*HALF_W-1:0] out_res,
  input  logic [3:0]              out_flags,
  output int                      mismatches,
  output int                      proto_errs,
  output int                      checked,
  output int                      pending
);

  logic                    s_live;
  logic                    s_valid;
  logic [LANES*DBL_W-1:0]  s_src;
  logic [2:0]              s_rm;
  int                      cyc = 0;
  int                      mism_cnt = 0;
  int                      proto_cnt = 0;
  int                      check_cnt = 0;
  int                      stamp_q [$];
  logic [LANES*HALF_W-1:0] res_q [$];
  logic [3:0]              flg_q [$];
  logic [LANES*DBL_W-1:0]  src_q [$];

  assign mismatches = mism_cnt;
  assign proto_errs = proto_cnt;
  assign checked    = check_cnt;
  assign pending    = stamp_q.size();

  // Exact conversion result packed as {res, nv, of, uf, nx}
  function automatic logic [19:0] convert(input logic [63:0] x, input logic [2:0] rm);
    logic        sgn;
    int          e;
    int          ex;
    int          shift;
    logic [63:0] m;
    logic [63:0] kept;
    logic        guard;
    logic        sticky;
    logic        inexact;
    logic        inc;
    logic        tiny;
    logic        to_inf;
    longint      enc;
    logic [19:0] r;
    sgn = x[63];
    e   = int'(x[62:52]);
    r   = '0;
    if (e == 2047) begin
      if (x[51:0] == '0) begin
        r[19:4] = {sgn, 15'h7c00};
      end else begin
        // Canonical NaN with nv only when the quiet bit is clear
        r[19:4] = 16'h7e00;
        r[3]    = ~x[51];
      end
    end else if (e == 0 && x[51:0] == '0) begin
      r[19:4] = {sgn, 15'h0000};
    end else begin
      // Value is m * 2^(ex-52)
      m    = (e == 0) ? {12'h000, x[51:0]} : {12'h001, x[51:0]};
      ex   = (e == 0) ? -1022 : e - 1023;
      tiny = ex < -14;
      // Half quantum is 2^(ex-10) or 2^-24 once tiny
      shift = (tiny ? -24 : ex - 10) - (ex - 52);
      if (shift > 54) begin
        kept   = '0;
        guard  = 1'b0;
        sticky = 1'b1;
      end else begin
        kept   = m >> shift;
        guard  = m[shift-1];
        sticky = (m & ((64'd1 << (shift - 1)) - 64'd1)) != '0;
      end
      inexact = guard | sticky;
      case (rm)
        3'd1:    inc = 1'b0;
        3'd2:    inc = sgn & inexact;
        3'd3:    inc = ~sgn & inexact;
        3'd4:    inc = guard;
        default: inc = guard & (sticky | kept[0]);
      endcase
      // Encoding counts in quanta so a carry bumps the exponent
      enc = longint'(kept) + longint'(inc);
      if (!tiny) begin
        enc = enc + longint'(ex + 14) * 1024;
      end
      if (enc >= 31 * 1024) begin
        case (rm)
          3'd1:    to_inf = 1'b0;
          3'd2:    to_inf = sgn;
          3'd3:    to_inf = ~sgn;
          default: to_inf = 1'b1;
        endcase
        r[19:4] = to_inf ? {sgn, 15'h7c00} : {sgn, 15'h7bff};
        r[2]    = 1'b1;
        r[0]    = 1'b1;
      end else begin
        r[19:4] = {sgn, enc[14:0]};
        r[1]    = tiny & inexact;
        r[0]    = inexact;
      end
    end
    return r;
  endfunction

  // Inputs taken where the DUT takes them
  always @(posedge forever_cpuclk) begin
    s_live  <= !reset;
    s_valid <= in_valid && !reset;
    s_src   <= in_src;
    s_rm    <= in_rm;
  end

  // Outputs checked mid-cycle
  always @(negedge forever_cpuclk) begin
    int                      stamp;
    logic [LANES*HALF_W-1:0] eres;
    logic [3:0]              eflg;
    logic [LANES*DBL_W-1:0]  esrc;
    logic [19:0]             lane;
    cyc++;
    if (s_live && $isunknown(out_valid)) begin
      proto_cnt++;
      $display("out_valid is unknown after reset at cycle %0d", cyc);
    end
    if (out_valid === 1'b1) begin
      if (stamp_q.size() == 0) begin
        proto_cnt++;
        $display("out_valid at cycle %0d has no matching input", cyc);
      end else begin
        stamp = stamp_q.pop_front();
        eres  = res_q.pop_front();
        eflg  = flg_q.pop_front();
        esrc  = src_q.pop_front();
        check_cnt++;
        if (stamp != cyc - 3) begin
          proto_cnt++;
          $display("Result for the input of cycle %0d came at cycle %0d", stamp, cyc);
        end
        for (int l = 0; l < LANES; l++) begin
          if (out_res[l*HALF_W +: HALF_W] !== eres[l*HALF_W +: HALF_W]) begin
            mism_cnt++;
            $display("MISMATCH out_res[%0d]: src %h expected %h got %h", l,
                     esrc[l*DBL_W +: DBL_W], eres[l*HALF_W +: HALF_W],
                     out_res[l*HALF_W +: HALF_W]);
          end
        end
        if (out_flags !== eflg) begin
          mism_cnt++;
          $display("MISMATCH out_flags: expected %h got %h", eflg, out_flags);
        end
      end
    end else if (stamp_q.size() != 0 && stamp_q[0] <= cyc - 3) begin
      proto_cnt++;
      $display("No out_valid for the input of cycle %0d", stamp_q[0]);
      void'(stamp_q.pop_front());
      void'(res_q.pop_front());
      void'(flg_q.pop_front());
      void'(src_q.pop_front());
    end
    if (s_valid) begin
      eres = '0;
      eflg = '0;
      for (int l = 0; l < LANES; l++) begin
        lane = convert(s_src[l*DBL_W +: DBL_W], s_rm);
        eres[l*HALF_W +: HALF_W] = lane[19:4];
        // Merged flags
        eflg = eflg | lane[3:0];
      end
      // The input edge fell in the previous cycle
      stamp_q.push_back(cyc - 1);
      res_q.push_back(eres);
      flg_q.push_back(eflg);
      src_q.push_back(s_src);
    end
  end

endmodule

// File: testbench/tb_fcnvt.sv
`timescale 1ns/1ps

module tb_fcnvt
  import fcnvt_pkg::*;
();

  localparam int LANES        = 4;
  localparam int NUM_VEC      = 2000;
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;
  // About 70 percent valid, so allow two cycles per vector plus drain
  localparam int WATCHDOG_NS  = (RESET_CYCLES + 2 * NUM_VEC + 100) * CLK_PERIOD;

  logic                    forever_cpuclk;
  logic                    reset;
  logic                    in_valid;
  logic [LANES*DBL_W-1:0]  in_src;
  rm_t                     in_rm;
  logic                    out_valid;
  logic [LANES*HALF_W-1:0] out_res;
  fflags_t                 out_flags;
  int                      mismatches;
  int                      proto_errs;
  int                      checked;
  int                      pending;
  logic [31:0]             lcg_state = 32'hd10c;

  fcnvt_dtoh_top #(
    .LANES (LANES)
  ) fcnvt_dtoh_top_i (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_src         (in_src),
    .in_rm          (in_rm),
    .out_valid      (out_valid),
    .out_res        (out_res),
    .out_flags      (out_flags)
  );

  fcnvt_checker #(
    .LANES (LANES)
  ) checker_i (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_src         (in_src),
    .in_rm          (in_rm),
    .out_valid      (out_valid),
    .out_res        (out_res),
    .out_flags      (out_flags),
    .mismatches     (mismatches),
    .proto_errs     (proto_errs),
    .checked        (checked),
    .pending        (pending)
  );

  // LCG step, upper half only since the low bits cycle fast
  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  function automatic logic [31:0] rand32();
    logic [15:0] hi;
    logic [15:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi, lo};
  endfunction

  // Random binary64 with the exponent picked from weighted bands
  function automatic logic [63:0] make_operand();
    logic [31:0] r;
    logic [31:0] r2;
    logic [63:0] w;
    logic [10:0] e;
    logic [51:0] f;
    int          band;
    int          shape;
    r     = rand32();
    r2    = rand32();
    w     = {rand32(), rand32()};
    f     = w[51:0];
    band  = int'(r[15:0] % 16'd100);
    shape = int'(r[23:16] % 8'd4);
    if (band < 35) begin
      // Normal half range, 2^-14 up to 2^15
      e = 11'(1009 + r2 % 30);
    end else if (band < 55) begin
      // Half subnormal range, a little below the smallest subnormal
      e = 11'(996 + r2 % 13);
    end else if (band < 70) begin
      // Top binade and just above it
      e = 11'(1038 + r2 % 4);
    end else if (band < 78) begin
      // Far too small, binary64 subnormals included
      e = r2[0] ? 11'd0 : 11'(r2 % 990);
    end else if (band < 86) begin
      e = '0;
      f = '0;
    end else begin
      // Infinity or NaN
      e = '1;
      if (r2[1]) begin
        f = '0;
      end
    end
    if (band < 70) begin
      // Exact ties and rounding carries
      if (shape == 0) begin
        f[40:0] = '0;
      end else if (shape == 1) begin
        f[51:42] = '1;
      end
    end
    return {r[31], e, f};
  endfunction

  initial begin
    forever_cpuclk = 1'b0;
    forever #(CLK_PERIOD / 2) forever_cpuclk = ~forever_cpuclk;
  end

  // Stimulus on the falling edge
  initial begin
    int          sent;
    int          count_err;
    logic [31:0] r;
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_src    = '0;
    in_rm     = RNE;
    sent      = 0;
    count_err = 0;
    repeat (RESET_CYCLES) @(negedge forever_cpuclk);
    reset = 1'b0;
    while (sent < NUM_VEC) begin
      @(negedge forever_cpuclk);
      r        = rand32();
      in_valid = (r[15:0] % 16'd100) < 16'd70;
      if (in_valid) begin
        for (int l = 0; l < LANES; l++) begin
          in_src[l*DBL_W +: DBL_W] = make_operand();
        end
        r     = rand32();
        in_rm = rm_t'(3'(r % 5));
        sent++;
      end
    end
    @(negedge forever_cpuclk);
    in_valid = 1'b0;
    // Let the last vector reach the checker queue, then drain
    repeat (2) @(negedge forever_cpuclk);
    wait (pending == 0);
    repeat (4) @(negedge forever_cpuclk);
    if (checked != NUM_VEC) begin
      $display("Vector count wrong: %0d sent but %0d checked", NUM_VEC, checked);
      count_err = 1;
    end
    $display("Errors: %0d mismatches, %0d protocol, %0d count; %0d vectors checked",
             mismatches, proto_errs, count_err, checked);
    if (mismatches + proto_errs + count_err == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run did not finish within %0d ns, %0d vectors checked",
             WATCHDOG_NS, checked);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: src.f
logic/fcnvt_pkg.sv
logic/fcnvt_lane_if.sv
logic/fcnvt_dtoh_sh.sv
logic/fcnvt_dtoh_lane.sv
logic/fcnvt_dispatch.sv
logic/fcnvt_collect.sv
logic/fcnvt_dtoh_top.sv
testbench/fcnvt_checker.sv
testbench/tb_fcnvt.sv

// File: Makefile
# Verilator simulation of the multi-lane double-to-half converter

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_fcnvt \
		-f src.f --Mdir obj_dir -o tb_fcnvt
	./obj_dir/tb_fcnvt 2>&1 | tee sim.log
	@if grep -q "Test failures found" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "All tests passed!" sim.log; then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
